//--- hdl/bitsyncPkg.sv
package bitsyncPkg;

    // ------------------------------------------------------------------------
    // widths and register map
    // ------------------------------------------------------------------------
    localparam int sampleW   = 18;   // sample and DAC word width
    localparam int accW      = 40;   // DC lag accumulator width
    localparam int dcShiftUp = 16;   // sample scaling ahead of the lag shift
    localparam int busAdrW   = 3;    // word address bits on the bus

    localparam logic [busAdrW-1:0] addrMode   = 3'd0;
    localparam logic [busAdrW-1:0] addrCh0Cfg = 3'd1;
    localparam logic [busAdrW-1:0] addrCh1Cfg = 3'd2;
    localparam logic [busAdrW-1:0] addrCh0Dc  = 3'd3;  // read only
    localparam logic [busAdrW-1:0] addrCh1Dc  = 3'd4;  // read only

    // ------------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        modeIndependent = 2'd0,  // two unrelated PCM streams
        modeSingle      = 2'd1,
        modeDual        = 2'd2,  // QPSK, I on ch0 and Q on ch1
        modeOffset      = 2'd3   // OQPSK, Q lags I by half a symbol
    } bitsyncModeT;

    typedef enum logic [3:0] {
        dacAdc = 4'd0,
        dacDc  = 4'd1,
        dacSym = 4'd2
    } dacSelT;

    // ------------------------------------------------------------------------
    // grouped signals
    // ------------------------------------------------------------------------
    typedef struct packed {
        dacSelT       dac0Sel;
        dacSelT       dac1Sel;
        dacSelT       dac2Sel;
        logic         dcEnable;
        logic [4:0]   dcGain;   // lag shift exponent
        logic [7:0]   dcTest;   // forced offset when nonzero
    } chanCfgT;

    typedef struct packed {
        logic signed [sampleW-1:0] sample;
        logic                      sampleEn;
        logic                      sym2xEn;
        logic                      symEn;
        logic [sampleW-1:0]        symData;
        logic                      symBit;
    } chanInT;

    typedef struct packed {
        logic               en;
        logic [sampleW-1:0] data;
    } dacOutT;

    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [busAdrW-1:0] adr;
        logic [3:0]         sel;
        logic [31:0]        dat;
    } wbReqT;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wbRspT;

endpackage

//--- hdl/bitsyncRegs.sv
`timescale 1ns/1ps

module bitsyncRegs (
    input  logic                           clk,
    input  logic                           rstN,
    input  bitsyncPkg::wbReqT              wbReq,
    output bitsyncPkg::wbRspT              wbRsp,
    input  logic [bitsyncPkg::sampleW-1:0] ch0Offset,
    input  logic [bitsyncPkg::sampleW-1:0] ch1Offset,
    output bitsyncPkg::bitsyncModeT        mode,
    output bitsyncPkg::chanCfgT            ch0Cfg,
    output bitsyncPkg::chanCfgT            ch1Cfg
);

    logic        reqValid;
    logic [31:0] rdMux;
    logic [31:0] wrWord;

    function automatic logic [31:0] mergeLanes(
        input logic [31:0] cur,
        input logic [31:0] dat,
        input logic [3:0]  sel
    );
        logic [31:0] res;
        res = cur;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = dat[8*i +: 8];
            end
        end
        return res;
    endfunction

    // a held request is answered every second cycle since ack blocks the next one
    assign reqValid = wbReq.cyc && wbReq.stb && !wbRsp.ack;

    always_comb begin
        case (wbReq.adr)
            bitsyncPkg::addrMode:   rdMux = 32'(mode);
            bitsyncPkg::addrCh0Cfg: rdMux = 32'(ch0Cfg);
            bitsyncPkg::addrCh1Cfg: rdMux = 32'(ch1Cfg);
            bitsyncPkg::addrCh0Dc:  rdMux = 32'(ch0Offset);  // live offsets, zero extended
            bitsyncPkg::addrCh1Dc:  rdMux = 32'(ch1Offset);
            default:                rdMux = '0;
        endcase
    end

    // for the writable words the read mux already holds the current contents
    assign wrWord = mergeLanes(rdMux, wbReq.dat, wbReq.sel);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbRsp  <= '0;
            mode   <= bitsyncPkg::modeIndependent;
            ch0Cfg <= '0;
            ch1Cfg <= '0;
        end else begin
            wbRsp.ack <= reqValid;
            if (reqValid) begin
                wbRsp.dat <= rdMux;
            end
            if (reqValid && wbReq.we) begin
                case (wbReq.adr)
                    bitsyncPkg::addrMode:
                        mode <= bitsyncPkg::bitsyncModeT'(wrWord[1:0]);
                    bitsyncPkg::addrCh0Cfg:
                        ch0Cfg <= bitsyncPkg::chanCfgT'(wrWord[$bits(bitsyncPkg::chanCfgT)-1:0]);
                    bitsyncPkg::addrCh1Cfg:
                        ch1Cfg <= bitsyncPkg::chanCfgT'(wrWord[$bits(bitsyncPkg::chanCfgT)-1:0]);
                    default: ;  // offsets are read only
                endcase
            end
        end
    end

    ackSingle: assert property (@(posedge clk) disable iff (!rstN)
        wbRsp.ack |=> !wbRsp.ack)
        else $error("wishbone ack held for two cycles");

endmodule

//--- hdl/dcLoopFilter.sv
`timescale 1ns/1ps

module dcLoopFilter (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic                                  en,
    input  logic signed [bitsyncPkg::sampleW-1:0] sample,
    input  bitsyncPkg::chanCfgT                   cfg,
    output logic [bitsyncPkg::sampleW-1:0]        offset
);

    logic signed [bitsyncPkg::accW-1:0] sampleExt;
    logic signed [bitsyncPkg::accW-1:0] scaled;
    logic signed [bitsyncPkg::accW-1:0] lagTerm;
    logic signed [bitsyncPkg::accW-1:0] acc;
    logic signed [bitsyncPkg::accW:0]   accSum;  // one guard bit above the accumulator

    assign sampleExt = bitsyncPkg::accW'(sample);             // sign extension
    assign scaled    = sampleExt <<< bitsyncPkg::dcShiftUp;
    assign lagTerm   = scaled >>> cfg.dcGain;                 // larger gain code is a slower loop
    assign accSum    = acc + lagTerm;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            acc <= '0;
        end else if (en) begin
            if (cfg.dcEnable) begin
                acc <= acc + lagTerm;
            end else begin
                acc <= '0;  // loop held at zero while disabled
            end
        end
    end

    // the test value lands in the top byte of the offset word
    assign offset = (cfg.dcTest != '0) ? {cfg.dcTest, 10'b0}
                                       : acc[bitsyncPkg::accW-1 -: bitsyncPkg::sampleW];

    // a small gain code on a large offset would wrap the accumulator
    accNoWrap: assert property (@(posedge clk) disable iff (!rstN)
        (en && cfg.dcEnable) |-> (accSum[bitsyncPkg::accW] == accSum[bitsyncPkg::accW-1]))
        else $error("dc accumulator wrapped around on a lag step");

endmodule

//--- hdl/ambiguityResolver.sv
`timescale 1ns/1ps

module ambiguityResolver (
    input  logic                    clk,
    input  logic                    rstN,
    input  bitsyncPkg::bitsyncModeT mode,
    input  logic [1:0]              rotation,
    input  logic                    ch0SymEn,
    input  logic                    ch1SymEn,
    input  logic                    ch0BitIn,
    input  logic                    ch1BitIn,
    output logic                    ch0Bit,
    output logic                    ch1Bit
);

    logic quadMode;   // both bits belong to one QPSK or OQPSK symbol
    logic qDelay;     // Q from the previous strobe
    logic qRot;       // Q as seen by the swapping rotations
    logic rot0Bit;
    logic rot1Bit;

    assign quadMode = (mode == bitsyncPkg::modeDual) || (mode == bitsyncPkg::modeOffset);

    // in OQPSK the swapped Q has to come from the earlier half symbol
    assign qRot = (mode == bitsyncPkg::modeOffset) ? qDelay : ch1BitIn;

    // ------------------------------------------------------------------------
    // phase rotation table, I on ch0 and Q on ch1
    // ------------------------------------------------------------------------
    always_comb begin
        case (rotation)
            2'd0: begin
                rot0Bit = ch0BitIn;
                rot1Bit = ch1BitIn;
            end
            2'd1: begin
                rot0Bit = qRot;
                rot1Bit = ~ch0BitIn;
            end
            2'd2: begin
                rot0Bit = ~ch0BitIn;
                rot1Bit = ~ch1BitIn;
            end
            default: begin
                rot0Bit = ~qRot;
                rot1Bit = ch0BitIn;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ch0Bit <= 1'b0;
            ch1Bit <= 1'b0;
            qDelay <= 1'b0;
        end else if (quadMode) begin
            if (ch0SymEn) begin     // ch0 strobe clocks both bits
                ch0Bit <= rot0Bit;
                ch1Bit <= rot1Bit;
                if (mode == bitsyncPkg::modeOffset) begin
                    qDelay <= ch1BitIn;
                end
            end
        end else begin
            if (ch0SymEn) begin
                ch0Bit <= ch0BitIn;
            end
            if (ch1SymEn) begin
                ch1Bit <= ch1BitIn;
            end
        end
    end

endmodule

//--- hdl/dacMonitorMux.sv
`timescale 1ns/1ps

module dacMonitorMux (
    input  logic                           clk,
    input  logic                           rstN,
    input  bitsyncPkg::chanCfgT            cfg,
    input  bitsyncPkg::chanInT             chan,
    input  logic                           dcEn,
    input  logic                           symEn2x,
    input  logic [bitsyncPkg::sampleW-1:0] offset,
    output bitsyncPkg::dacOutT             dac0,
    output bitsyncPkg::dacOutT             dac1,
    output bitsyncPkg::dacOutT             dac2
);

    // same source decode for all three converters
    function automatic bitsyncPkg::dacOutT pickSource(input bitsyncPkg::dacSelT sel);
        bitsyncPkg::dacOutT res;
        case (sel)
            bitsyncPkg::dacDc: begin
                res.en   = dcEn;
                res.data = offset;
            end
            bitsyncPkg::dacSym: begin
                res.en   = symEn2x;
                res.data = chan.symData;
            end
            default: begin  // unknown codes fall back to the raw samples
                res.en   = chan.sampleEn;
                res.data = chan.sample;
            end
        endcase
        return res;
    endfunction

    // ------------------------------------------------------------------------
    // output registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dac0 <= '0;
            dac1 <= '0;
            dac2 <= '0;
        end else begin
            dac0 <= pickSource(cfg.dac0Sel);
            dac1 <= pickSource(cfg.dac1Sel);
            dac2 <= pickSource(cfg.dac2Sel);
        end
    end

endmodule

//--- hdl/bitsyncTop.sv
`timescale 1ns/1ps

module bitsyncTop (
    input  logic                           clk,
    input  logic                           rstN,
    input  bitsyncPkg::wbReqT              wbReq,
    output bitsyncPkg::wbRspT              wbRsp,
    input  logic [1:0]                     rotation,
    input  bitsyncPkg::chanInT             ch0In,
    input  bitsyncPkg::chanInT             ch1In,
    output logic                           ch0Bit,
    output logic                           ch1Bit,
    output logic                           asyncMode,
    output logic [bitsyncPkg::sampleW-1:0] ch0Offset,
    output logic [bitsyncPkg::sampleW-1:0] ch1Offset,
    output bitsyncPkg::dacOutT             ch0Dac0,
    output bitsyncPkg::dacOutT             ch0Dac1,
    output bitsyncPkg::dacOutT             ch0Dac2,
    output bitsyncPkg::dacOutT             ch1Dac0,
    output bitsyncPkg::dacOutT             ch1Dac1,
    output bitsyncPkg::dacOutT             ch1Dac2
);

    bitsyncPkg::bitsyncModeT mode;
    bitsyncPkg::chanCfgT     ch0Cfg;
    bitsyncPkg::chanCfgT     ch1Cfg;
    logic                    ch1Sym2xEn;  // ch1 half symbol strobe after mode selection

    // ------------------------------------------------------------------------
    // mode decode
    // ------------------------------------------------------------------------
    assign asyncMode = (mode == bitsyncPkg::modeIndependent)
                    || (mode == bitsyncPkg::modeSingle);

    // sync modes run both channels on the ch0 symbol timing
    assign ch1Sym2xEn = asyncMode ? ch1In.sym2xEn : ch0In.sym2xEn;

    bitsyncRegs regs (
        .clk(clk), .rstN(rstN),
        .wbReq(wbReq), .wbRsp(wbRsp),
        .ch0Offset(ch0Offset), .ch1Offset(ch1Offset),
        .mode(mode), .ch0Cfg(ch0Cfg), .ch1Cfg(ch1Cfg)
    );

    // ------------------------------------------------------------------------
    // DC offset loops
    // ------------------------------------------------------------------------
    dcLoopFilter ch0DcLoop (
        .clk(clk), .rstN(rstN), .en(ch0In.sym2xEn),
        .sample(ch0In.sample), .cfg(ch0Cfg), .offset(ch0Offset)
    );

    dcLoopFilter ch1DcLoop (
        .clk(clk), .rstN(rstN), .en(ch1Sym2xEn),
        .sample(ch1In.sample), .cfg(ch1Cfg), .offset(ch1Offset)
    );

    ambiguityResolver resolver (
        .clk(clk), .rstN(rstN), .mode(mode), .rotation(rotation),
        .ch0SymEn(ch0In.symEn), .ch1SymEn(ch1In.symEn),
        .ch0BitIn(ch0In.symBit), .ch1BitIn(ch1In.symBit),
        .ch0Bit(ch0Bit), .ch1Bit(ch1Bit)
    );

    // ------------------------------------------------------------------------
    // monitor DACs
    // ------------------------------------------------------------------------
    dacMonitorMux ch0DacMux (
        .clk(clk), .rstN(rstN), .cfg(ch0Cfg), .chan(ch0In),
        .dcEn(ch0In.sym2xEn), .symEn2x(ch0In.sym2xEn), .offset(ch0Offset),
        .dac0(ch0Dac0), .dac1(ch0Dac1), .dac2(ch0Dac2)
    );

    dacMonitorMux ch1DacMux (
        .clk(clk), .rstN(rstN), .cfg(ch1Cfg), .chan(ch1In),
        .dcEn(ch1Sym2xEn), .symEn2x(ch1Sym2xEn), .offset(ch1Offset),
        .dac0(ch1Dac0), .dac1(ch1Dac1), .dac2(ch1Dac2)
    );

endmodule

//--- testbench/bitsyncTb.sv
`timescale 1ns/1ps

module bitsyncTb;

    localparam int numRows    = 17;
    localparam int cycleLimit = numRows * 20 + 500;
    localparam int dcSample   = -20000;
    localparam int dcSteps    = 6;
    localparam int dcGainSet  = 2;

    typedef struct packed {
        bitsyncPkg::bitsyncModeT mode;
        logic [1:0]              rot;
        logic                    en0;   // ch0 symbol strobe
        logic                    en1;   // ch1 symbol strobe
        logic                    i;     // ch0 input bit
        logic                    q;     // ch1 input bit
        logic                    exp0;
        logic                    exp1;
    } rowT;

    logic                           clk;
    logic                           rstN;
    bitsyncPkg::wbReqT              wbReq;
    bitsyncPkg::wbRspT              wbRsp;
    logic [1:0]                     rotation;
    bitsyncPkg::chanInT             ch0In;
    bitsyncPkg::chanInT             ch1In;
    logic                           ch0Bit;
    logic                           ch1Bit;
    logic                           asyncMode;
    logic [bitsyncPkg::sampleW-1:0] ch0Offset;
    logic [bitsyncPkg::sampleW-1:0] ch1Offset;
    bitsyncPkg::dacOutT             ch0Dac0, ch0Dac1, ch0Dac2;
    bitsyncPkg::dacOutT             ch1Dac0, ch1Dac1, ch1Dac2;

    rowT         rows [numRows];
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    logic [31:0] seedVal;
    logic [17:0] dcExp;
    logic        asyncExp;

    bitsyncTop UUT (
        .clk(clk), .rstN(rstN), .wbReq(wbReq), .wbRsp(wbRsp), .rotation(rotation),
        .ch0In(ch0In), .ch1In(ch1In), .ch0Bit(ch0Bit), .ch1Bit(ch1Bit),
        .asyncMode(asyncMode), .ch0Offset(ch0Offset), .ch1Offset(ch1Offset),
        .ch0Dac0(ch0Dac0), .ch0Dac1(ch0Dac1), .ch0Dac2(ch0Dac2),
        .ch1Dac0(ch1Dac0), .ch1Dac1(ch1Dac1), .ch1Dac2(ch1Dac2)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycleCount <= cycleCount + 1;

    initial begin
        wait (cycleCount >= cycleLimit);
        $display("simulation stopped after %0d cycles without finishing", cycleCount);
        $display("TEST FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // checking and bus helpers
    // ------------------------------------------------------------------------
    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // called on a falling edge, returns on the falling edge after ack dropped
    task automatic busTransfer(input logic we, input logic [2:0] adr, input logic [3:0] sel,
                               input logic [31:0] dat, output logic [31:0] data);
        int waits;
        waits = 0;
        wbReq.cyc = 1'b1;
        wbReq.stb = 1'b1;
        wbReq.we  = we;
        wbReq.adr = adr;
        wbReq.sel = sel;
        wbReq.dat = dat;
        @(negedge clk);
        while (!wbRsp.ack && waits < 8) begin
            @(negedge clk);
            waits++;
        end
        data      = wbRsp.dat;
        wbReq.cyc = 1'b0;
        wbReq.stb = 1'b0;
        if (!wbRsp.ack) begin
            errorCount++;
            $display("no wishbone ack within 8 cycles at address %0d", adr);
        end else if (waits != 0) begin
            errorCount++;
            $display("wishbone ack came %0d cycles late at address %0d", waits, adr);
        end
        @(negedge clk);
        if (wbRsp.ack) begin
            errorCount++;
            $display("wishbone ack stayed high for a second cycle");
        end
    endtask

    task automatic busWrite(input logic [2:0] adr, input logic [3:0] sel, input logic [31:0] dat);
        logic [31:0] unused;
        busTransfer(1'b1, adr, sel, dat, unused);
    endtask

    task automatic busRead(input logic [2:0] adr, input logic [31:0] exp, input string name);
        logic [31:0] data;
        busTransfer(1'b0, adr, 4'hF, 32'h0, data);
        checkVal(name, data, exp);
    endtask

    function automatic logic [31:0] cfgWord(input logic [3:0] s0, input logic [3:0] s1,
                                            input logic [3:0] s2, input logic dcOn,
                                            input logic [4:0] gain, input logic [7:0] test);
        bitsyncPkg::chanCfgT cfg;
        cfg.dac0Sel  = bitsyncPkg::dacSelT'(s0);
        cfg.dac1Sel  = bitsyncPkg::dacSelT'(s1);
        cfg.dac2Sel  = bitsyncPkg::dacSelT'(s2);
        cfg.dcEnable = dcOn;
        cfg.dcGain   = gain;
        cfg.dcTest   = test;
        return 32'(cfg);
    endfunction

    // n lag steps of a constant sample, offset taken from the top 18 accumulator bits
    function automatic logic [17:0] dcExpect(input int n, input int s, input int gain);
        longint term;
        longint accum;
        term  = (longint'(s) <<< bitsyncPkg::dcShiftUp) >>> gain;
        accum = longint'(n) * term;
        return accum[39:22];
    endfunction

    task automatic runDacPhase(input bitsyncPkg::bitsyncModeT m, input int cycles);
        bitsyncPkg::chanInT prev0;
        bitsyncPkg::chanInT prev1;
        logic [31:0]        rnd;
        logic               syncMode;
        logic               en1;
        syncMode = (m == bitsyncPkg::modeDual) || (m == bitsyncPkg::modeOffset);
        busWrite(bitsyncPkg::addrMode, 4'b0001, 32'(m));
        for (int c = 0; c < cycles; c++) begin
            rnd = $urandom();
            ch0In.sample   = rnd[17:0];
            ch0In.sampleEn = rnd[18];
            ch0In.sym2xEn  = rnd[19];
            ch1In.sampleEn = rnd[20];
            ch1In.sym2xEn  = rnd[21];
            rnd = $urandom();
            ch1In.sample = rnd[17:0];
            rnd = $urandom();
            ch0In.symData = rnd[17:0];
            rnd = $urandom();
            ch1In.symData = rnd[17:0];
            prev0 = ch0In;
            prev1 = ch1In;
            @(negedge clk);
            en1 = syncMode ? prev0.sym2xEn : prev1.sym2xEn;  // ch1 follows ch0 timing when synced
            checkVal("ch0Dac0", 32'(ch0Dac0), 32'({prev0.sampleEn, prev0.sample}));
            checkVal("ch0Dac1", 32'(ch0Dac1), 32'({prev0.sym2xEn, 8'h21, 10'b0}));
            checkVal("ch0Dac2", 32'(ch0Dac2), 32'({prev0.sym2xEn, prev0.symData}));
            checkVal("ch1Dac0", 32'(ch1Dac0), 32'({en1, prev1.symData}));
            checkVal("ch1Dac1", 32'(ch1Dac1), 32'({prev1.sampleEn, prev1.sample}));
            checkVal("ch1Dac2", 32'(ch1Dac2), 32'({en1, 8'h0C, 10'b0}));
        end
        ch0In = '0;
        ch1In = '0;
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        seedVal  = $urandom(32'h1cbc);
        rstN     = 1'b0;
        wbReq    = '0;
        ch0In    = '0;
        ch1In    = '0;
        rotation = 2'd0;
        // independent rows use i and q as the two unrelated channel bits
        rows = '{
            '{bitsyncPkg::modeIndependent, 2'd0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0},
            '{bitsyncPkg::modeIndependent, 2'd0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1},
            '{bitsyncPkg::modeIndependent, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
            '{bitsyncPkg::modeSingle,      2'd0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},
            '{bitsyncPkg::modeDual,        2'd0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0},
            '{bitsyncPkg::modeDual,        2'd1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
            '{bitsyncPkg::modeDual,        2'd2, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1},
            '{bitsyncPkg::modeDual,        2'd3, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1},
            '{bitsyncPkg::modeDual,        2'd1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1},
            '{bitsyncPkg::modeDual,        2'd3, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
            '{bitsyncPkg::modeDual,        2'd0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0},
            '{bitsyncPkg::modeOffset,      2'd0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1},
            '{bitsyncPkg::modeOffset,      2'd1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1},
            '{bitsyncPkg::modeOffset,      2'd3, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0},
            '{bitsyncPkg::modeOffset,      2'd1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0},
            '{bitsyncPkg::modeOffset,      2'd3, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1},
            '{bitsyncPkg::modeOffset,      2'd2, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1}
        };
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkVal("ch0Bit", 32'(ch0Bit), 32'h0);
        checkVal("asyncMode", 32'(asyncMode), 32'h1);

        // register access with partial byte selects, only 26 cfg bits are stored
        busWrite(bitsyncPkg::addrCh1Cfg, 4'hF, 32'hFFFF_FFFF);
        busWrite(bitsyncPkg::addrCh1Cfg, 4'b0010, 32'h0000_1200);
        busRead(bitsyncPkg::addrCh1Cfg, 32'h03FF_12FF, "ch1Cfg");
        busWrite(bitsyncPkg::addrCh1Cfg, 4'b1001, 32'h5500_0034);
        busRead(bitsyncPkg::addrCh1Cfg, 32'h01FF_1234, "ch1Cfg");
        busWrite(bitsyncPkg::addrMode, 4'hF, 32'h0000_0002);
        busWrite(bitsyncPkg::addrMode, 4'b0000, 32'h0000_0003);
        busRead(bitsyncPkg::addrMode, 32'h0000_0002, "mode");
        for (int a = 5; a < 8; a++) begin
            busRead(3'(a), 32'h0, "unmapped");
        end
        busWrite(bitsyncPkg::addrCh1Cfg, 4'hF, 32'h0);

        // DC loop on ch0 with a constant sample
        dcExp = dcExpect(dcSteps, dcSample, dcGainSet);
        busWrite(bitsyncPkg::addrCh0Cfg, 4'hF, cfgWord(4'd0, 4'd1, 4'd2, 1'b1, 5'(dcGainSet), 8'h0));
        ch0In.sample  = bitsyncPkg::sampleW'(dcSample);
        ch0In.sym2xEn = 1'b1;
        repeat (dcSteps) @(negedge clk);
        ch0In.sym2xEn = 1'b0;
        checkVal("ch0Offset", 32'(ch0Offset), 32'(dcExp));
        busRead(bitsyncPkg::addrCh0Dc, 32'(dcExp), "ch0Dc readback");
        busWrite(bitsyncPkg::addrCh0Cfg, 4'b0001, 32'h0000_005A);
        checkVal("ch0Offset", 32'(ch0Offset), 32'({8'h5A, 10'b0}));
        busWrite(bitsyncPkg::addrCh0Cfg, 4'hF, cfgWord(4'd0, 4'd1, 4'd2, 1'b0, 5'(dcGainSet), 8'h0));
        checkVal("ch0Offset", 32'(ch0Offset), 32'(dcExp));   // accumulator holds until the next enable
        ch0In.sym2xEn = 1'b1;
        @(negedge clk);
        ch0In.sym2xEn = 1'b0;
        checkVal("ch0Offset", 32'(ch0Offset), 32'h0);
        ch0In.sample = '0;

        // ambiguity resolution table
        for (int r = 0; r < numRows; r++) begin
            busWrite(bitsyncPkg::addrMode, 4'b0001, 32'(rows[r].mode));
            rotation      = rows[r].rot;
            ch0In.symEn   = rows[r].en0;
            ch1In.symEn   = rows[r].en1;
            ch0In.symBit  = rows[r].i;
            ch1In.symBit  = rows[r].q;
            @(negedge clk);
            ch0In.symEn = 1'b0;
            ch1In.symEn = 1'b0;
            asyncExp = (rows[r].mode == bitsyncPkg::modeIndependent)
                    || (rows[r].mode == bitsyncPkg::modeSingle);
            checkVal($sformatf("ch0Bit row %0d", r), 32'(ch0Bit), 32'(rows[r].exp0));
            checkVal($sformatf("ch1Bit row %0d", r), 32'(ch1Bit), 32'(rows[r].exp1));
            checkVal($sformatf("asyncMode row %0d", r), 32'(asyncMode), 32'(asyncExp));
        end

        // DAC monitor mux, ch1 dac1 uses an undefined code that falls back to the samples
        busWrite(bitsyncPkg::addrCh0Cfg, 4'hF, cfgWord(4'd0, 4'd1, 4'd2, 1'b0, 5'd0, 8'h21));
        busWrite(bitsyncPkg::addrCh1Cfg, 4'hF, cfgWord(4'd2, 4'hF, 4'd1, 1'b0, 5'd0, 8'h0C));
        checkVal("ch1Offset", 32'(ch1Offset), 32'({8'h0C, 10'b0}));
        busRead(bitsyncPkg::addrCh1Dc, 32'({8'h0C, 10'b0}), "ch1Dc readback");
        runDacPhase(bitsyncPkg::modeIndependent, 40);
        runDacPhase(bitsyncPkg::modeDual, 40);

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
hdl/bitsyncPkg.sv
hdl/bitsyncRegs.sv
hdl/dcLoopFilter.sv
hdl/ambiguityResolver.sv
hdl/dacMonitorMux.sv
hdl/bitsyncTop.sv
testbench/bitsyncTb.sv

//--- run.sh
#!/bin/sh
# build and run the bit synchronizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module bitsyncTb -o simBitsync

./obj_dir/simBitsync > sim.log
cat sim.log

# the run passes only if the testbench printed its pass line
grep -qx "TEST PASS" sim.log
